// File: hw/pte_cache_pkg.sv
package pte_cache_pkg;

    localparam int VADDR_W  = 32;
    localparam int PADDR_W  = 34;
    localparam int PTE_W    = 32;
    localparam int VPN_W    = 10;
    localparam int OFFSET_W = 12;

    // Sv32 PTE flag positions
    localparam int PTE_V     = 0;
    localparam int PTE_R     = 1;
    localparam int PTE_W_BIT = 2;
    localparam int PTE_X     = 3;
    localparam int PTE_U     = 4;
    localparam int PTE_G     = 5;
    localparam int PTE_A     = 6;
    localparam int PTE_D     = 7;

    localparam int PTE_RSW_LO  = 8;  // 2 bits
    localparam int PTE_PPN0_LO = 10; // 10 bits
    localparam int PTE_PPN1_LO = 20; // 12 bits

    // Access source
    localparam logic [1:0] SRC_FETCH = 2'b00;
    localparam logic [1:0] SRC_LOAD  = 2'b01;
    localparam logic [1:0] SRC_STORE = 2'b10;

    localparam logic [1:0] MODE_U = 2'b00;
    localparam logic [1:0] MODE_S = 2'b01;

    // Same address seen as a 4 KiB page or as a 4 MiB superpage
    typedef union packed {
        struct packed {
            logic [VPN_W-1:0]    vpn1;
            logic [VPN_W-1:0]    vpn0;
            logic [OFFSET_W-1:0] offset;
        } page;
        struct packed {
            logic [VPN_W-1:0]          vpn1;
            logic [VPN_W+OFFSET_W-1:0] offset;
        } superpage;
    } vaddr_u;

endpackage

// File: hw/pte_cache_ctrl.sv
`timescale 1ns/1ps

module pte_cache_ctrl (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              req,
    input  logic [pte_cache_pkg::VADDR_W-1:0] req_vaddr,
    input  logic [1:0]                        req_source,
    input  logic                              flush,
    input  logic                              walk_full,
    input  logic                              hit0,
    input  logic                              hit1,
    input  logic [pte_cache_pkg::PTE_W-1:0]   entry0,
    input  logic [pte_cache_pkg::PTE_W-1:0]   entry1,
    input  logic                              misaligned1,
    input  logic                              fault0,
    input  logic                              fault1,
    input  logic [pte_cache_pkg::PADDR_W-1:0] paddr0,
    input  logic [pte_cache_pkg::PADDR_W-1:0] paddr1,
    output logic [pte_cache_pkg::VADDR_W-1:0] buf_vaddr,
    output logic [1:0]                        buf_source,
    output logic                              resp_valid,
    output logic                              resp_exception,
    output logic                              resp_error,
    output logic [pte_cache_pkg::PTE_W-1:0]   resp_entry,
    output logic [pte_cache_pkg::VADDR_W-1:0] resp_vaddr,
    output logic [1:0]                        resp_source,
    output logic                              resp_level,
    output logic                              walk_req,
    output logic [pte_cache_pkg::VADDR_W-1:0] walk_vaddr,
    output logic [1:0]                        walk_source,
    output logic [1:0]                        walk_hit_mask,
    output logic [pte_cache_pkg::PADDR_W-1:0] walk_paddr0,
    output logic [pte_cache_pkg::PADDR_W-1:0] walk_paddr1,
    output logic                              refill_ready
);

    logic       buf_req;
    logic [1:0] hit;
    logic [1:0] hit_first;
    logic [1:0] leaf;
    logic [1:0] exc;
    logic [1:0] leaf_hit;
    logic       usable;

    // Lookup stage, stores are read in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_req <= 1'b0;
        end else begin
            buf_req <= req;
        end
    end

    always_ff @(posedge clk) begin
        buf_vaddr  <= req_vaddr;
        buf_source <= req_source;
    end

    assign hit = {hit1, hit0};

    assign leaf[0] = entry0[pte_cache_pkg::PTE_R] | entry0[pte_cache_pkg::PTE_W_BIT] |
                     entry0[pte_cache_pkg::PTE_X];
    assign leaf[1] = entry1[pte_cache_pkg::PTE_R] | entry1[pte_cache_pkg::PTE_W_BIT] |
                     entry1[pte_cache_pkg::PTE_X];

    assign exc[0] = fault0;
    assign exc[1] = fault1 | (leaf[1] & misaligned1); // Superpage with ppn0 set

    // Level 1 wins when both levels hit
    always_comb begin
        hit_first = 2'b00;
        if (hit[1]) begin
            hit_first = 2'b10;
        end else if (hit[0]) begin
            hit_first = 2'b01;
        end
    end

    assign leaf_hit = hit & leaf;
    assign usable   = |(hit_first & (leaf | exc));

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
            walk_req   <= 1'b0;
        end else begin
            resp_valid <= buf_req & (usable | walk_full) & ~flush;
            walk_req   <= buf_req & ~usable & ~walk_full & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        resp_exception <= |(hit_first & exc);
        resp_error     <= ~usable & walk_full;
        resp_entry     <= leaf_hit[0] ? entry0 : entry1;
        resp_vaddr     <= buf_vaddr;
        resp_source    <= buf_source;
        resp_level     <= hit_first[1];

        walk_vaddr    <= buf_vaddr;
        walk_source   <= buf_source;
        walk_hit_mask <= hit_first; // Walker resumes below the deepest pointer
        walk_paddr0   <= paddr0;
        walk_paddr1   <= paddr1;
    end

    // Store ports are shared, a lookup always takes them
    assign refill_ready = ~req;

endmodule

// File: hw/pte_level_store.sv
`timescale 1ns/1ps

module pte_level_store #(
    parameter int LEVEL = 0,
    parameter int SETS  = 16,
    parameter int BANK  = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      req,
    input  logic [pte_cache_pkg::VADDR_W-1:0]         req_vaddr,
    input  logic                                      flush,
    input  logic                                      refill_req,
    input  logic [1:0]                                refill_level_mask,
    input  logic [pte_cache_pkg::VADDR_W-1:0]         refill_vaddr,
    input  logic [BANK-1:0][pte_cache_pkg::PTE_W-1:0] refill_line,
    output logic                                      hit,
    output logic [pte_cache_pkg::PTE_W-1:0]           entry,
    output logic                                      misaligned
);

    localparam int KEY_W  = (LEVEL == 0) ? 2 * pte_cache_pkg::VPN_W : pte_cache_pkg::VPN_W;
    localparam int BANK_W = $clog2(BANK);
    localparam int SET_W  = $clog2(SETS);
    localparam int TAG_W  = KEY_W - SET_W - BANK_W;

    pte_cache_pkg::vaddr_u req_va;
    pte_cache_pkg::vaddr_u refill_va;
    logic [KEY_W-1:0]      req_key;
    logic [KEY_W-1:0]      refill_key;
    logic [SET_W-1:0]      idx;
    logic                  write_en;
    logic [BANK-1:0]       refill_mis;

    logic [SETS-1:0]                         valid_q;
    logic [TAG_W-1:0]                        tag_q  [SETS];
    logic [BANK-1:0]                         mis_q  [SETS];
    logic [BANK-1:0][pte_cache_pkg::PTE_W-1:0] line_q [SETS];

    logic                                      lk_q;
    logic                                      rd_valid_q;
    logic [TAG_W-1:0]                          rd_tag_q;
    logic [BANK-1:0]                           rd_mis_q;
    logic [BANK-1:0][pte_cache_pkg::PTE_W-1:0] rd_line_q;
    logic [TAG_W-1:0]                          lk_tag_q;
    logic [BANK_W-1:0]                         lk_bank_q;

    assign req_va    = req_vaddr;
    assign refill_va = refill_vaddr;

    generate
        if (LEVEL == 0) begin : g_full_vpn
            assign req_key    = {req_va.page.vpn1, req_va.page.vpn0};
            assign refill_key = {refill_va.page.vpn1, refill_va.page.vpn0};
        end else begin : g_vpn1
            assign req_key    = req_va.page.vpn1;
            assign refill_key = refill_va.page.vpn1;
        end
    endgenerate

    // Key layout is tag | set | bank
    assign idx      = req ? req_key[BANK_W +: SET_W] : refill_key[BANK_W +: SET_W];
    assign write_en = refill_req & refill_level_mask[LEVEL] & ~req;

    // Leaf with nonzero ppn0
    always_comb begin
        for (int i = 0; i < BANK; i++) begin
            refill_mis[i] = (refill_line[i][pte_cache_pkg::PTE_R] |
                             refill_line[i][pte_cache_pkg::PTE_W_BIT] |
                             refill_line[i][pte_cache_pkg::PTE_X]) &
                            (|refill_line[i][pte_cache_pkg::PTE_PPN0_LO +: pte_cache_pkg::VPN_W]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (write_en) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_q[idx]  <= refill_key[KEY_W-1 -: TAG_W];
            mis_q[idx]  <= refill_mis;
            line_q[idx] <= refill_line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lk_q <= 1'b0;
        end else begin
            lk_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rd_valid_q <= valid_q[idx];
            rd_tag_q   <= tag_q[idx];
            rd_mis_q   <= mis_q[idx];
            rd_line_q  <= line_q[idx];
            lk_tag_q   <= req_key[KEY_W-1 -: TAG_W];
            lk_bank_q  <= req_key[BANK_W-1:0];
        end
    end

    assign hit        = lk_q & rd_valid_q & (rd_tag_q == lk_tag_q) & ~flush;
    assign entry      = rd_line_q[lk_bank_q];
    assign misaligned = rd_mis_q[lk_bank_q];

endmodule

// File: hw/pte_perm_check.sv
`timescale 1ns/1ps

module pte_perm_check (
    input  logic [pte_cache_pkg::PTE_W-1:0] entry,
    input  logic [1:0]                      source,
    input  logic [1:0]                      priv_mode,
    input  logic                            sum,
    input  logic                            mxr,
    output logic                            fault
);

    logic v, r, w, x, u, a, d;
    logic is_fetch, is_load, is_store;
    logic leaf;
    logic type_ok;
    logic priv_bad;

    assign v = entry[pte_cache_pkg::PTE_V];
    assign r = entry[pte_cache_pkg::PTE_R];
    assign w = entry[pte_cache_pkg::PTE_W_BIT];
    assign x = entry[pte_cache_pkg::PTE_X];
    assign u = entry[pte_cache_pkg::PTE_U];
    assign a = entry[pte_cache_pkg::PTE_A];
    assign d = entry[pte_cache_pkg::PTE_D];

    assign is_fetch = source == pte_cache_pkg::SRC_FETCH;
    assign is_load  = source == pte_cache_pkg::SRC_LOAD;
    assign is_store = source == pte_cache_pkg::SRC_STORE;

    assign leaf = r | w | x;

    // MXR makes executable pages readable
    assign type_ok = (r & is_load) | (x & (is_fetch | (is_load & mxr))) | (w & is_store);

    assign priv_bad = ((priv_mode == pte_cache_pkg::MODE_S) & u & ~sum) |
                      ((priv_mode == pte_cache_pkg::MODE_U) & ~u);

    assign fault = ~v | (w & ~r) |
                   (|entry[pte_cache_pkg::PTE_RSW_LO +: 2]) |
                   (leaf & (~type_ok | priv_bad | ~a | (is_store & ~d)));

endmodule

// File: hw/pte_paddr_gen.sv
`timescale 1ns/1ps

module pte_paddr_gen #(
    parameter int LEVEL = 0
) (
    input  logic [pte_cache_pkg::PTE_W-1:0]   entry,
    input  logic [pte_cache_pkg::VADDR_W-1:0] vaddr,
    output logic [pte_cache_pkg::PADDR_W-1:0] paddr
);

    pte_cache_pkg::vaddr_u va;
    logic                  leaf;

    assign va   = vaddr;
    assign leaf = entry[pte_cache_pkg::PTE_R] | entry[pte_cache_pkg::PTE_W_BIT] |
                  entry[pte_cache_pkg::PTE_X];

    generate
        if (LEVEL == 0) begin : g_page
            assign paddr = {entry[pte_cache_pkg::PTE_W-1:pte_cache_pkg::PTE_PPN0_LO],
                            va.page.offset};
        end else begin : g_super
            // Leaf maps a 4 MiB superpage, pointer gives the level-0 PTE address
            assign paddr = leaf ?
                {entry[pte_cache_pkg::PTE_W-1:pte_cache_pkg::PTE_PPN1_LO], va.superpage.offset} :
                {entry[pte_cache_pkg::PTE_W-1:pte_cache_pkg::PTE_PPN0_LO], va.page.vpn0, 2'b00};
        end
    endgenerate

endmodule

// File: hw/pte_cache_top.sv
`timescale 1ns/1ps

module pte_cache_top #(
    parameter int L0_SETS = 16,
    parameter int L1_SETS = 8,
    parameter int BANK    = 4
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    req,
    input  logic [pte_cache_pkg::VADDR_W-1:0]       req_vaddr,
    input  logic [1:0]                              req_source,
    input  logic                                    flush,
    input  logic [1:0]                              priv_mode,
    input  logic                                    sum,
    input  logic                                    mxr,
    output logic                                    resp_valid,
    output logic                                    resp_exception,
    output logic                                    resp_error,
    output logic [pte_cache_pkg::PTE_W-1:0]         resp_entry,
    output logic [pte_cache_pkg::VADDR_W-1:0]       resp_vaddr,
    output logic [1:0]                              resp_source,
    output logic                                    resp_level,
    output logic                                    walk_req,
    output logic [pte_cache_pkg::VADDR_W-1:0]       walk_vaddr,
    output logic [1:0]                              walk_source,
    output logic [1:0]                              walk_hit_mask,
    output logic [pte_cache_pkg::PADDR_W-1:0]       walk_paddr0,
    output logic [pte_cache_pkg::PADDR_W-1:0]       walk_paddr1,
    input  logic                                    walk_full,
    input  logic                                    refill_req,
    input  logic [1:0]                              refill_level_mask,
    input  logic [pte_cache_pkg::VADDR_W-1:0]       refill_vaddr,
    input  logic [BANK-1:0][pte_cache_pkg::PTE_W-1:0] refill_line,
    output logic                                    refill_ready
);

    logic                               hit0, hit1;
    logic [pte_cache_pkg::PTE_W-1:0]    entry0, entry1;
    logic                               misaligned1;
    logic                               fault0, fault1;
    logic [pte_cache_pkg::PADDR_W-1:0]  paddr0, paddr1;
    logic [pte_cache_pkg::VADDR_W-1:0]  buf_vaddr;
    logic [1:0]                         buf_source;

    pte_cache_ctrl u_ctrl (.*);

    pte_level_store #(.LEVEL(0), .SETS(L0_SETS), .BANK(BANK)) u_store0 (
        .clk, .reset, .req, .req_vaddr, .flush,
        .refill_req, .refill_level_mask, .refill_vaddr, .refill_line,
        .hit        (hit0),
        .entry      (entry0),
        .misaligned () // Superpage check only
    );

    pte_level_store #(.LEVEL(1), .SETS(L1_SETS), .BANK(BANK)) u_store1 (
        .clk, .reset, .req, .req_vaddr, .flush,
        .refill_req, .refill_level_mask, .refill_vaddr, .refill_line,
        .hit        (hit1),
        .entry      (entry1),
        .misaligned (misaligned1)
    );

    pte_perm_check u_perm0 (
        .entry (entry0), .source (buf_source), .priv_mode, .sum, .mxr, .fault (fault0)
    );

    pte_perm_check u_perm1 (
        .entry (entry1), .source (buf_source), .priv_mode, .sum, .mxr, .fault (fault1)
    );

    pte_paddr_gen #(.LEVEL(0)) u_paddr0 (.entry (entry0), .vaddr (buf_vaddr), .paddr (paddr0));
    pte_paddr_gen #(.LEVEL(1)) u_paddr1 (.entry (entry1), .vaddr (buf_vaddr), .paddr (paddr1));

endmodule

// File: verification/pte_cache_sva.sv
`timescale 1ns/1ps

module pte_cache_sva #(
    parameter int L0_SETS = 4,
    parameter int L1_SETS = 4,
    parameter int BANK    = 4
) (
    input logic                                      clk,
    input logic                                      reset,
    input logic                                      req,
    input logic [31:0]                               req_vaddr,
    input logic [1:0]                                req_source,
    input logic                                      flush,
    input logic [1:0]                                priv_mode,
    input logic                                      sum,
    input logic                                      mxr,
    input logic                                      resp_valid,
    input logic                                      resp_exception,
    input logic                                      resp_error,
    input logic [31:0]                               resp_entry,
    input logic [31:0]                               resp_vaddr,
    input logic [1:0]                                resp_source,
    input logic                                      resp_level,
    input logic                                      walk_req,
    input logic [31:0]                               walk_vaddr,
    input logic [1:0]                                walk_source,
    input logic [1:0]                                walk_hit_mask,
    input logic [33:0]                               walk_paddr0,
    input logic [33:0]                               walk_paddr1,
    input logic                                      walk_full,
    input logic                                      refill_req,
    input logic [1:0]                                refill_level_mask,
    input logic [31:0]                               refill_vaddr,
    input logic [BANK-1:0][pte_cache_pkg::PTE_W-1:0] refill_line,
    input logic                                      refill_ready
);

    localparam int BW  = $clog2(BANK);
    localparam int SW0 = $clog2(L0_SETS);
    localparam int SW1 = $clog2(L1_SETS);

    int fail_count = 0;

    // Shadow copy of refilled lines, keyed by the VPN above the bank bits
    logic                  sh_valid0 [L0_SETS];
    logic [19:0]           sh_key0   [L0_SETS];
    logic [BANK-1:0][31:0] sh_line0  [L0_SETS];
    logic                  sh_valid1 [L1_SETS];
    logic [9:0]            sh_key1   [L1_SETS];
    logic [BANK-1:0][31:0] sh_line1  [L1_SETS];

    logic [19:0] rk0, fk0;
    logic [9:0]  rk1, fk1;
    logic        s1_req, s1_hit0, s1_hit1;
    logic [31:0] s1_e0, s1_e1, s1_vaddr;
    logic [1:0]  s1_src;
    logic        leaf0, leaf1, exc0, exc1, usable;

    logic        exp_resp, exp_walk, exp_exc, exp_err, exp_level, chk_entry, chk_p0, chk_p1;
    logic [31:0] exp_entry, exp_vaddr;
    logic [1:0]  exp_src, exp_mask;
    logic [33:0] exp_p0, exp_p1;

    function automatic logic is_leaf(logic [31:0] e);
        return e[pte_cache_pkg::PTE_R] | e[pte_cache_pkg::PTE_W_BIT] | e[pte_cache_pkg::PTE_X];
    endfunction

    // Sv32 permission rules, one condition at a time
    function automatic logic perm_fault(logic [31:0] e, logic [1:0] src, logic [1:0] mode,
                                        logic sm, logic mx);
        logic allowed;
        if (!e[pte_cache_pkg::PTE_V]) return 1'b1;
        if (e[pte_cache_pkg::PTE_W_BIT] && !e[pte_cache_pkg::PTE_R]) return 1'b1;
        if (e[pte_cache_pkg::PTE_RSW_LO +: 2] != 2'b00) return 1'b1;
        if (!is_leaf(e)) return 1'b0;
        case (src)
            pte_cache_pkg::SRC_FETCH: allowed = e[pte_cache_pkg::PTE_X];
            pte_cache_pkg::SRC_LOAD:  allowed = e[pte_cache_pkg::PTE_R] |
                                                (mx & e[pte_cache_pkg::PTE_X]);
            pte_cache_pkg::SRC_STORE: allowed = e[pte_cache_pkg::PTE_W_BIT];
            default:                  allowed = 1'b0;
        endcase
        if (!allowed) return 1'b1;
        if (mode == pte_cache_pkg::MODE_S && e[pte_cache_pkg::PTE_U] && !sm) return 1'b1;
        if (mode == pte_cache_pkg::MODE_U && !e[pte_cache_pkg::PTE_U]) return 1'b1;
        if (!e[pte_cache_pkg::PTE_A]) return 1'b1;
        if (src == pte_cache_pkg::SRC_STORE && !e[pte_cache_pkg::PTE_D]) return 1'b1;
        return 1'b0;
    endfunction

    assign rk0 = req_vaddr[31:12];
    assign rk1 = req_vaddr[31:22];
    assign fk0 = refill_vaddr[31:12];
    assign fk1 = refill_vaddr[31:22];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < L0_SETS; i++) sh_valid0[i] <= 1'b0;
            for (int i = 0; i < L1_SETS; i++) sh_valid1[i] <= 1'b0;
        end else if (refill_req && !req) begin
            if (refill_level_mask[0]) begin
                sh_valid0[fk0[BW +: SW0]] <= 1'b1;
                sh_key0[fk0[BW +: SW0]]   <= fk0 >> BW;
                sh_line0[fk0[BW +: SW0]]  <= refill_line;
            end
            if (refill_level_mask[1]) begin
                sh_valid1[fk1[BW +: SW1]] <= 1'b1;
                sh_key1[fk1[BW +: SW1]]   <= fk1 >> BW;
                sh_line1[fk1[BW +: SW1]]  <= refill_line;
            end
        end
    end

    // Store lookup one cycle after the request
    always_ff @(posedge clk) begin
        s1_req   <= req & ~reset;
        s1_vaddr <= req_vaddr;
        s1_src   <= req_source;
        s1_hit0  <= sh_valid0[rk0[BW +: SW0]] && sh_key0[rk0[BW +: SW0]] == (rk0 >> BW);
        s1_hit1  <= sh_valid1[rk1[BW +: SW1]] && sh_key1[rk1[BW +: SW1]] == (rk1 >> BW);
        s1_e0    <= sh_line0[rk0[BW +: SW0]][rk0[BW-1:0]];
        s1_e1    <= sh_line1[rk1[BW +: SW1]][rk1[BW-1:0]];
    end

    assign leaf0  = is_leaf(s1_e0);
    assign leaf1  = is_leaf(s1_e1);
    assign exc0   = perm_fault(s1_e0, s1_src, priv_mode, sum, mxr);
    assign exc1   = perm_fault(s1_e1, s1_src, priv_mode, sum, mxr) | (leaf1 & (|s1_e1[19:10]));
    assign usable = s1_hit1 ? (leaf1 | exc1) : (s1_hit0 & (leaf0 | exc0));

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_resp <= 1'b0;
            exp_walk <= 1'b0;
        end else begin
            exp_resp <= s1_req & ~flush & (usable | walk_full);
            exp_walk <= s1_req & ~flush & ~usable & ~walk_full;
        end
        exp_exc   <= s1_hit1 ? exc1 : (s1_hit0 & exc0);
        exp_err   <= ~usable & walk_full;
        exp_level <= s1_hit1;
        chk_entry <= (s1_hit0 & leaf0) | (s1_hit1 & leaf1);
        exp_entry <= (s1_hit0 & leaf0) ? s1_e0 : s1_e1;
        exp_vaddr <= s1_vaddr;
        exp_src   <= s1_src;
        exp_mask  <= {s1_hit1, s1_hit0 & ~s1_hit1};
        chk_p0    <= s1_hit0;
        chk_p1    <= s1_hit1;
        exp_p0    <= {s1_e0[31:10], s1_vaddr[11:0]};
        exp_p1    <= leaf1 ? {s1_e1[31:20], s1_vaddr[21:0]}
                           : {s1_e1[31:10], s1_vaddr[21:12], 2'b00};
    end

    a_resp_valid: assert property (@(posedge clk) disable iff (reset) resp_valid == exp_resp)
        else begin
            fail_count++;
            $error("FAILED resp_valid %h exp %h", resp_valid, exp_resp);
        end
    a_walk_req: assert property (@(posedge clk) disable iff (reset) walk_req == exp_walk)
        else begin
            fail_count++;
            $error("FAILED walk_req %h exp %h", walk_req, exp_walk);
        end
    a_exception: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> resp_exception == exp_exc)
        else begin
            fail_count++;
            $error("FAILED resp_exception %h exp %h", resp_exception, exp_exc);
        end
    a_error: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> resp_error == exp_err)
        else begin
            fail_count++;
            $error("FAILED resp_error %h exp %h", resp_error, exp_err);
        end
    a_level: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> resp_level == exp_level)
        else begin
            fail_count++;
            $error("FAILED resp_level %h exp %h", resp_level, exp_level);
        end
    a_resp_vaddr: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> resp_vaddr == exp_vaddr)
        else begin
            fail_count++;
            $error("FAILED resp_vaddr %h exp %h", resp_vaddr, exp_vaddr);
        end
    a_resp_source: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> resp_source == exp_src)
        else begin
            fail_count++;
            $error("FAILED resp_source %h exp %h", resp_source, exp_src);
        end
    a_entry: assert property (@(posedge clk) disable iff (reset)
        resp_valid && chk_entry |-> resp_entry == exp_entry)
        else begin
            fail_count++;
            $error("FAILED resp_entry %h exp %h", resp_entry, exp_entry);
        end
    a_walk_vaddr: assert property (@(posedge clk) disable iff (reset)
        walk_req |-> walk_vaddr == exp_vaddr)
        else begin
            fail_count++;
            $error("FAILED walk_vaddr %h exp %h", walk_vaddr, exp_vaddr);
        end
    a_walk_source: assert property (@(posedge clk) disable iff (reset)
        walk_req |-> walk_source == exp_src)
        else begin
            fail_count++;
            $error("FAILED walk_source %h exp %h", walk_source, exp_src);
        end
    a_walk_mask: assert property (@(posedge clk) disable iff (reset)
        walk_req |-> walk_hit_mask == exp_mask)
        else begin
            fail_count++;
            $error("FAILED walk_hit_mask %h exp %h", walk_hit_mask, exp_mask);
        end
    a_paddr0: assert property (@(posedge clk) disable iff (reset)
        (resp_valid || walk_req) && chk_p0 |-> walk_paddr0 == exp_p0)
        else begin
            fail_count++;
            $error("FAILED walk_paddr0 %h exp %h", walk_paddr0, exp_p0);
        end
    a_paddr1: assert property (@(posedge clk) disable iff (reset)
        (resp_valid || walk_req) && chk_p1 |-> walk_paddr1 == exp_p1)
        else begin
            fail_count++;
            $error("FAILED walk_paddr1 %h exp %h", walk_paddr1, exp_p1);
        end
    a_ready: assert property (@(posedge clk) refill_ready == !req)
        else begin
            fail_count++;
            $error("FAILED refill_ready %h exp %h", refill_ready, !req);
        end

endmodule

bind pte_cache_top pte_cache_sva #(.L0_SETS(L0_SETS), .L1_SETS(L1_SETS), .BANK(BANK)) u_sva (.*);

// File: verification/pte_cache_tb.sv
`timescale 1ns/1ps

module pte_cache_tb;

    localparam int BANK        = 4;
    localparam int RANDOM_OPS  = 400;
    localparam int WATCHDOG_CY = 300 + RANDOM_OPS * 2 + 500; // Directed, random, margin

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  req = 1'b0, flush = 1'b0, sum = 1'b0, mxr = 1'b0;
    logic [31:0]           req_vaddr = '0, refill_vaddr = '0;
    logic [1:0]            req_source = '0, priv_mode = pte_cache_pkg::MODE_S;
    logic                  walk_full = 1'b0, refill_req = 1'b0;
    logic [1:0]            refill_level_mask = '0;
    logic [BANK-1:0][31:0] refill_line = '0;
    logic                  resp_valid, resp_exception, resp_error, resp_level, walk_req;
    logic [31:0]           resp_entry, resp_vaddr, walk_vaddr;
    logic [1:0]            resp_source, walk_source, walk_hit_mask;
    logic [33:0]           walk_paddr0, walk_paddr1;
    logic                  refill_ready;
    logic                  flush_pend = 1'b0;
    logic [BANK-1:0][31:0] line;

    pte_cache_top #(.L0_SETS(4), .L1_SETS(4), .BANK(BANK)) dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CY * 8);
        $display("TEST FAILED");
        $fatal(1, "timeout, simulation did not finish in time");
    end

    always @(negedge clk) begin
        if (dut.u_sva.fail_count != 0) begin
            $display("TEST FAILED");
            $fatal(1, "assertion failure reported by checker");
        end
    end

    function automatic logic [31:0] make_pte(logic [21:0] ppn, logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    task automatic lookup(input logic [31:0] va, input logic [1:0] src, input logic fl);
        @(posedge clk);
        req        <= 1'b1;
        req_vaddr  <= va;
        req_source <= src;
        refill_req <= 1'b0;
        flush      <= flush_pend;
        flush_pend = fl;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        req        <= 1'b0;
        refill_req <= 1'b0;
        flush      <= flush_pend;
        flush_pend = 1'b0;
    endtask

    task automatic refill(input logic [1:0] mask, input logic [31:0] va,
                          input logic [BANK-1:0][31:0] ln);
        @(posedge clk);
        req               <= 1'b0;
        refill_req        <= 1'b1;
        refill_level_mask <= mask;
        refill_vaddr      <= va;
        refill_line       <= ln;
        flush             <= flush_pend;
        flush_pend = 1'b0;
    endtask

    task automatic fill_line(input logic [21:0] ppn, input logic [7:0] flags);
        for (int i = 0; i < BANK; i++) line[i] = make_pte(ppn + 22'(i), flags);
    endtask

    task automatic random_line();
        for (int i = 0; i < BANK; i++) begin
            line[i] = make_pte(22'($urandom), 8'($urandom));
            line[i][0] = ($urandom % 8) != 0; // Mostly valid
            if (($urandom % 6) == 0) line[i][9:8] = 2'($urandom);
        end
    endtask

    initial begin
        void'($urandom(32'h546c_5578));
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (3) idle_cycle();

        // Empty cache: walk, then error under walk_full
        lookup({10'd3, 10'd7, 12'h123}, pte_cache_pkg::SRC_LOAD, 1'b0);
        repeat (3) idle_cycle();
        walk_full <= 1'b1;
        lookup({10'd3, 10'd8, 12'h456}, pte_cache_pkg::SRC_STORE, 1'b0);
        repeat (3) idle_cycle();
        walk_full <= 1'b0;

        // Level-0 leaves
        fill_line(22'h1200, 8'hcf);
        refill(2'b01, {10'd1, 10'd4, 12'h0}, line);
        for (int b = 0; b < BANK; b++) begin
            lookup({10'd1, 10'd4 + 10'(b), 12'h0ab}, 2'($urandom % 3), 1'b0);
        end
        repeat (3) idle_cycle();

        // Level-1 leaf wins, then a misaligned superpage
        fill_line(22'h1400, 8'hcf);
        for (int i = 0; i < BANK; i++) line[i][19:10] = '0;
        refill(2'b10, {10'd1, 10'd0, 12'h0}, line);
        lookup({10'd1, 10'd5, 12'h0cd}, pte_cache_pkg::SRC_LOAD, 1'b0);
        repeat (3) idle_cycle();
        fill_line(22'h1401, 8'hcf);
        refill(2'b10, {10'd1, 10'd0, 12'h0}, line);
        lookup({10'd1, 10'd5, 12'h0cd}, pte_cache_pkg::SRC_LOAD, 1'b0);
        repeat (3) idle_cycle();

        // Permission sweep on level-0 leaves
        for (int k = 0; k < 40; k++) begin
            random_line();
            refill(2'b01, {10'd5, 10'(k % 16), 12'h0}, line);
            priv_mode <= 2'($urandom % 2);
            sum       <= 1'($urandom);
            mxr       <= 1'($urandom);
            lookup({10'd5, 10'(k % 16), 12'($urandom)}, 2'($urandom % 3), 1'b0);
        end
        repeat (3) idle_cycle();

        // Level-1 pointer gives a walk
        fill_line(22'h2a5, 8'h01);
        refill(2'b10, {10'd9, 10'd0, 12'h0}, line);
        lookup({10'd9, 10'd33, 12'h777}, pte_cache_pkg::SRC_FETCH, 1'b0);
        repeat (3) idle_cycle();

        // Flush cancels, also with back-to-back lookups
        lookup({10'd1, 10'd4, 12'h010}, pte_cache_pkg::SRC_LOAD, 1'b1);
        lookup({10'd9, 10'd2, 12'h020}, pte_cache_pkg::SRC_LOAD, 1'b1);
        lookup({10'd3, 10'd2, 12'h030}, pte_cache_pkg::SRC_LOAD, 1'b0);
        repeat (3) idle_cycle();

        for (int n = 0; n < RANDOM_OPS; n++) begin
            walk_full <= ($urandom % 5) == 0;
            priv_mode <= 2'($urandom % 2);
            sum       <= 1'($urandom);
            mxr       <= 1'($urandom);
            if (($urandom % 3) == 0) begin
                random_line();
                refill(2'($urandom % 3 + 1), {10'($urandom % 8), 10'($urandom % 16), 12'h0}, line);
            end else if (($urandom % 4) == 0) begin
                idle_cycle();
            end else begin
                lookup({10'($urandom % 8), 10'($urandom % 16), 12'($urandom)},
                       2'($urandom % 3), ($urandom % 8) == 0);
            end
        end
        repeat (5) idle_cycle();

        if (dut.u_sva.fail_count != 0) begin
            $display("TEST FAILED");
            $fatal(1, "assertion failure reported by checker");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: pte_cache_top.f
hw/pte_cache_pkg.sv
hw/pte_cache_ctrl.sv
hw/pte_level_store.sv
hw/pte_perm_check.sv
hw/pte_paddr_gen.sv
hw/pte_cache_top.sv
verification/pte_cache_sva.sv
verification/pte_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pte_cache_tb
FILELIST  ?= pte_cache_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
